// ==== src.f ====
+incdir+tb
rtl/cnn_dims_pkg.sv
rtl/cnn_num_pkg.sv
rtl/pixel_counter.sv
rtl/frame_ctrl.sv
rtl/line_buffer.sv
rtl/conv_unit.sv
rtl/pool_unit.sv
rtl/dense_argmax.sv
rtl/lenet_lite_top.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_top -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_top 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== tb/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// golden model of the network, img[row][col] holds one frame in raster order

// one conv map value after bias and ReLU, window corner at image (cr+4, cc+4)
function automatic acc_t conv_value(input pixel_t img [IMAGE_SIZE][IMAGE_SIZE],
		input int m, input int cr, input int cc);
	int sum;
	int br;
	int bc;
	br = cr + KERNEL - 1;	// bottom right corner of the window
	bc = cc + KERNEL - 1;
	sum = int'(CONV_BIAS[m]);
	for (int r = 0; r < KERNEL; r++)
		for (int c = 0; c < KERNEL; c++)
			sum += int'(img[br-r][bc-c]) * int'(KERNEL_TAPS[m][r][c]);	// taps count back
	if (sum < 0)
		sum = 0;	// ReLU
	return acc_t'(sum);
endfunction

// max of the 2x2 block of conv values
function automatic acc_t pooled_value(input pixel_t img [IMAGE_SIZE][IMAGE_SIZE],
		input int m, input int pr, input int pc);
	acc_t best;
	acc_t v;
	best = '0;	// conv values are never below zero after ReLU
	for (int dr = 0; dr < 2; dr++)
		for (int dc = 0; dc < 2; dc++) begin
			v = conv_value(img, m, 2 * pr + dr, 2 * pc + dc);
			if (v > best)
				best = v;
		end
	return best;
endfunction

// class with the highest dense score
function automatic logic [CLASS_W-1:0] best_class(input pixel_t img [IMAGE_SIZE][IMAGE_SIZE]);
	longint score [NUM_CLASSES];
	longint pv;
	int idx;
	int top;
	for (int k = 0; k < NUM_CLASSES; k++)
		score[k] = 0;
	for (int m = 0; m < NUM_MAPS; m++)
		for (int pr = 0; pr < POOL_SIZE; pr++)
			for (int pc = 0; pc < POOL_SIZE; pc++) begin
				pv = longint'(pooled_value(img, m, pr, pc));
				idx = m * POOL_SIZE * POOL_SIZE + pr * POOL_SIZE + pc;	// map major input index
				for (int k = 0; k < NUM_CLASSES; k++)
					score[k] += longint'(DENSE_WEIGHTS[k][idx]) * pv;
			end
	top = 0;
	for (int k = 1; k < NUM_CLASSES; k++)
		if (score[k] > score[top])
			top = k;	// ties stay with the lower class
	return CLASS_W'(top);
endfunction

`endif

// ==== tb/tb_top.sv ====
module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	import cnn_dims_pkg::*;
	import cnn_num_pkg::*;

	localparam int PIXELS = IMAGE_SIZE * IMAGE_SIZE;
	localparam int POOLS_PER_FRAME = POOL_SIZE * POOL_SIZE;
	localparam int NUM_FRAMES = 6;
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * PIXELS * 3 + 200;

	logic clk;
	logic reset;
	pixel_t pixel;
	logic pixel_valid;
	logic [CLASS_W-1:0] digit;
	logic result_valid;
	acc_t pool_out [NUM_MAPS];
	logic pool_valid;

	integer seed;
	pixel_t frame [IMAGE_SIZE][IMAGE_SIZE];	// frame being sent
	acc_t exp_pool_q [$];	// expected pooled values, maps interleaved per position
	logic [CLASS_W-1:0] exp_digit_q [$];
	acc_t exp_pool [NUM_MAPS];	// queue heads, stable at the rising edge
	logic [CLASS_W-1:0] exp_digit = '0;
	logic pool_pending = 1'b0;
	logic digit_pending = 1'b0;
	logic pool_checked = 1'b0;	// output was checked at the last rising edge
	logic result_checked = 1'b0;
	logic stream_started = 1'b0;
	int pools_seen = 0;
	int results_seen = 0;
	int frames_sent = 0;
	int cycle_count = 0;

	`include "tb_ref_model.svh"

	lenet_lite_top dut (
		.clk(clk), .reset(reset), .pixel(pixel), .pixel_valid(pixel_valid),
		.digit(digit), .result_valid(result_valid), .pool_out(pool_out), .pool_valid(pool_valid)
	);

	always #4 clk = ~clk;	// 8 ns period

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		stop_with_failure($sformatf("MISMATCH at %0t ns: %s", $time, msg));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			pixel_valid = 1'b0;
		end
	endtask

	task automatic load_random_frame();
		for (int r = 0; r < IMAGE_SIZE; r++)
			for (int c = 0; c < IMAGE_SIZE; c++)
				frame[r][c] = pixel_t'($random(seed));
	endtask

	task automatic load_flat_frame(input pixel_t value);
		for (int r = 0; r < IMAGE_SIZE; r++)
			for (int c = 0; c < IMAGE_SIZE; c++)
				frame[r][c] = value;
	endtask

	// raster order of pooled positions, both maps per position
	task automatic queue_expected();
		for (int pr = 0; pr < POOL_SIZE; pr++)
			for (int pc = 0; pc < POOL_SIZE; pc++)
				for (int m = 0; m < NUM_MAPS; m++)
					exp_pool_q.push_back(pooled_value(frame, m, pr, pc));
		exp_digit_q.push_back(best_class(frame));
	endtask

	// valid stays high after the last pixel so the next frame can follow at once
	task automatic send_frame(input bit gaps);
		int idle;
		queue_expected();
		frames_sent++;
		for (int r = 0; r < IMAGE_SIZE; r++)
			for (int c = 0; c < IMAGE_SIZE; c++) begin
				if (gaps && ($random(seed) & 3) == 0) begin
					idle = 1 + ($random(seed) & 1);
					repeat (idle) begin
						@(negedge clk);
						pixel_valid = 1'b0;
						pixel = pixel_t'($random(seed));	// junk on the bus during a gap
					end
				end
				@(negedge clk);
				pixel = frame[r][c];
				pixel_valid = 1'b1;
				stream_started = 1'b1;
			end
	endtask

	always @(posedge clk) begin
		pool_checked <= pool_valid && !reset;
		result_checked <= result_valid && !reset;
	end

	// retire checked entries and present the next heads
	always @(negedge clk) begin
		if (pool_checked && exp_pool_q.size() >= NUM_MAPS) begin
			for (int m = 0; m < NUM_MAPS; m++)
				void'(exp_pool_q.pop_front());
			pools_seen++;
		end
		if (result_checked && exp_digit_q.size() > 0) begin
			void'(exp_digit_q.pop_front());
			results_seen++;
		end
		pool_pending = exp_pool_q.size() >= NUM_MAPS;
		digit_pending = exp_digit_q.size() > 0;
		for (int m = 0; m < NUM_MAPS; m++)
			if (pool_pending)
				exp_pool[m] = exp_pool_q[m];
		if (digit_pending)
			exp_digit = exp_digit_q[0];
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_with_failure("timeout, the DUT did not deliver all results in time");
	end

	a_quiet_start: assert property (@(posedge clk) disable iff (reset)
			!stream_started |-> !pool_valid && !result_valid)
		else stop_with_failure("DUT output went active before any pixel was sent");

	a_pool_expected: assert property (@(posedge clk) disable iff (reset)
			pool_valid |-> pool_pending)
		else stop_with_failure("pooled value arrived when none was expected");

	for (genvar m = 0; m < NUM_MAPS; m++) begin : g_pool_chk
		a_pool_value: assert property (@(posedge clk) disable iff (reset)
				pool_valid && pool_pending |-> pool_out[m] == exp_pool[m])
			else report_mismatch($sformatf("pooled value %0d map %0d is %0d, expected %0d",
				pools_seen, m, pool_out[m], exp_pool[m]));
	end

	a_result_expected: assert property (@(posedge clk) disable iff (reset)
			result_valid |-> digit_pending)
		else stop_with_failure("result pulse arrived with no frame outstanding");

	a_digit_value: assert property (@(posedge clk) disable iff (reset)
			result_valid && digit_pending |-> digit == exp_digit)
		else report_mismatch($sformatf("frame %0d digit is %0d, expected %0d",
			results_seen, digit, exp_digit));

	a_result_pulse: assert property (@(posedge clk) disable iff (reset)
			result_valid |=> !result_valid)
		else stop_with_failure("result_valid stayed high for more than one cycle");

	a_pool_count: assert property (@(posedge clk) disable iff (reset)
			result_valid |-> pools_seen == POOLS_PER_FRAME * (results_seen + 1))
		else stop_with_failure("frame result came without exactly 16 pooled values");

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		pixel = '0;
		pixel_valid = 1'b0;
		seed = 55489;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		idle_cycles(6);	// outputs must stay low with no input
		load_random_frame();
		send_frame(1'b0);
		send_frame(1'b1);	// same pixels with random gaps
		idle_cycles(4);
		for (int f = 0; f < 3; f++) begin
			load_random_frame();
			send_frame(1'b0);	// back to back, no idle cycle
		end
		idle_cycles(3);
		load_flat_frame(pixel_t'(-5));	// drives both maps below zero, all pools 0 and digit 0
		send_frame(1'b0);
		idle_cycles(1);
		while (results_seen < frames_sent)
			@(negedge clk);
		idle_cycles(20);	// room for a stray pulse
		if (results_seen == NUM_FRAMES && frames_sent == NUM_FRAMES &&
				exp_pool_q.size() == 0 && exp_digit_q.size() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			stop_with_failure("frame or result count wrong at the end of the run");
		end
	end

endmodule

// ==== rtl/lenet_lite_top.sv ====
module lenet_lite_top (
	input logic clk,
	input logic reset,
	input cnn_num_pkg::pixel_t pixel,
	input logic pixel_valid,
	output logic [cnn_dims_pkg::CLASS_W-1:0] digit,
	output logic result_valid,
	output cnn_num_pkg::acc_t pool_out [cnn_dims_pkg::NUM_MAPS],
	output logic pool_valid
);
	import cnn_dims_pkg::*;
	import cnn_num_pkg::*;

	localparam int IMAGE_COLS = IMAGE_SIZE;
	localparam int CONV_COLS = IMAGE_COLS - KERNEL + 1;	// valid window positions per row
	localparam int POS_W = $clog2(IMAGE_COLS);

	logic [POS_W-1:0] col, row;	// position of the live pixel
	logic frame_last;
	logic conv_take, pool_take, frame_done;
	pixel_t taps [KERNEL-1];	// four earlier rows, same column
	acc_t conv_out [NUM_MAPS];
	logic conv_valid;

	pixel_counter #(.IMAGE_COLS(IMAGE_COLS)) u_pixel_counter (
		.clk(clk), .reset(reset), .pixel_valid(pixel_valid),
		.col(col), .row(row), .frame_last(frame_last)
	);

	frame_ctrl u_frame_ctrl (
		.clk(clk), .reset(reset), .pixel_valid(pixel_valid),
		.col(col), .row(row), .frame_last(frame_last),
		.conv_take(conv_take), .pool_take(pool_take), .frame_done(frame_done)
	);

	line_buffer #(.IMAGE_COLS(IMAGE_COLS)) u_line_buffer (
		.clk(clk), .reset(reset), .pixel_valid(pixel_valid),
		.pixel(pixel), .taps(taps)
	);

	conv_unit u_conv_unit (
		.clk(clk), .reset(reset), .pixel_valid(pixel_valid), .conv_take(conv_take),
		.pixel(pixel), .taps(taps), .conv_out(conv_out), .conv_valid(conv_valid)
	);

	pool_unit #(.CONV_COLS(CONV_COLS)) u_pool_unit (
		.clk(clk), .reset(reset), .conv_valid(conv_valid), .pool_take(pool_take),
		.conv_out(conv_out), .pool_out(pool_out), .pool_valid(pool_valid)
	);

	dense_argmax u_dense_argmax (
		.clk(clk), .reset(reset), .pool_valid(pool_valid), .pool_out(pool_out),
		.frame_done(frame_done), .digit(digit), .result_valid(result_valid)
	);

endmodule

// ==== rtl/dense_argmax.sv ====
module dense_argmax (
	input logic clk,
	input logic reset,
	input logic pool_valid,
	input cnn_num_pkg::acc_t pool_out [cnn_dims_pkg::NUM_MAPS],
	input logic frame_done,	// arrives with the last pooled value
	output logic [cnn_dims_pkg::CLASS_W-1:0] digit,
	output logic result_valid
);
	import cnn_dims_pkg::*;
	import cnn_num_pkg::*;

	localparam int POS_COUNT = POOL_SIZE * POOL_SIZE;	// pooled positions per map
	localparam int POS_W = $clog2(POS_COUNT);
	localparam int CNT_W = $clog2(POS_COUNT + 1);	// room for a full count

	logic [CNT_W-1:0] pool_cnt;	// pooled positions seen this frame
	logic [CNT_W-1:0] cnt_next;
	score_t scores [NUM_CLASSES];
	score_t score_next [NUM_CLASSES];	// includes the value on the bus now
	logic [CLASS_W-1:0] best;

	assign cnt_next = pool_cnt + CNT_W'(pool_valid);

	// position count selects the weight column, one per map
	always_comb begin
		for (int k = 0; k < NUM_CLASSES; k++) begin
			score_next[k] = scores[k];
			if (pool_valid) begin
				for (int m = 0; m < NUM_MAPS; m++)
					score_next[k] += score_t'(DENSE_WEIGHTS[k][m * POS_COUNT + int'(pool_cnt[POS_W-1:0])])
						* score_t'(pool_out[m]);
			end
		end
	end

	always_comb begin
		best = '0;
		for (int k = 1; k < NUM_CLASSES; k++)
			if (score_next[k] > score_next[best])
				best = CLASS_W'(k);	// strict compare, ties keep the lower index
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pool_cnt <= '0;
			result_valid <= 1'b0;
			for (int k = 0; k < NUM_CLASSES; k++)
				scores[k] <= '0;
		end else begin
			result_valid <= frame_done;
			if (frame_done) begin
				pool_cnt <= '0;	// ready for an overlapping frame
				for (int k = 0; k < NUM_CLASSES; k++)
					scores[k] <= '0;
			end else if (pool_valid) begin
				pool_cnt <= cnt_next;
				scores <= score_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frame_done)
			digit <= best;
	end

	assert property (@(posedge clk) disable iff (reset) frame_done |-> cnt_next == CNT_W'(POS_COUNT))
		else $error("frame ended after %0d pooled positions", cnt_next);

endmodule

// ==== rtl/pool_unit.sv ====
module pool_unit #(
	parameter int CONV_COLS = 8
) (
	input logic clk,
	input logic reset,
	input logic conv_valid,
	input logic pool_take,
	input cnn_num_pkg::acc_t conv_out [cnn_dims_pkg::NUM_MAPS],
	output cnn_num_pkg::acc_t pool_out [cnn_dims_pkg::NUM_MAPS],
	output logic pool_valid
);
	import cnn_dims_pkg::*;
	import cnn_num_pkg::*;

	localparam int COL_W = $clog2(CONV_COLS);
	localparam logic [COL_W-1:0] LAST_COL = COL_W'(CONV_COLS - 1);

	acc_t row_mem [NUM_MAPS][CONV_COLS];	// row above, replaced as the current row arrives
	acc_t left [NUM_MAPS];	// current row, one column back
	acc_t up_left [NUM_MAPS];	// row above, one column back, kept before its overwrite
	acc_t block_max [NUM_MAPS];
	logic [COL_W-1:0] ccol;	// conv column of the incoming result

	function automatic acc_t max2(input acc_t a, input acc_t b);
		return (a > b) ? a : b;
	endfunction

	always_ff @(posedge clk) begin
		if (reset)
			ccol <= '0;
		else if (conv_valid)
			ccol <= (ccol == LAST_COL) ? '0 : ccol + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (conv_valid) begin
			for (int m = 0; m < NUM_MAPS; m++) begin
				up_left[m] <= row_mem[m][ccol];	// read before write, still the row above
				row_mem[m][ccol] <= conv_out[m];
				left[m] <= conv_out[m];
			end
		end
	end

	always_comb begin
		for (int m = 0; m < NUM_MAPS; m++)
			block_max[m] = max2(max2(up_left[m], row_mem[m][ccol]), max2(left[m], conv_out[m]));
	end

	always_ff @(posedge clk) begin
		if (pool_take)
			pool_out <= block_max;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pool_valid <= 1'b0;
		else
			pool_valid <= pool_take;
	end

	// the delayed enable from frame_ctrl must meet the registered conv result
	assert property (@(posedge clk) disable iff (reset) pool_take |-> conv_valid)
		else $error("pool enable without a conv result");

endmodule

// ==== rtl/conv_unit.sv ====
module conv_unit (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input logic conv_take,
	input cnn_num_pkg::pixel_t pixel,
	input cnn_num_pkg::pixel_t taps [cnn_dims_pkg::KERNEL-1],
	output cnn_num_pkg::acc_t conv_out [cnn_dims_pkg::NUM_MAPS],
	output logic conv_valid
);
	import cnn_dims_pkg::*;
	import cnn_num_pkg::*;

	pixel_t column [KERNEL];	// newest column, [0] is the live pixel
	pixel_t win_q [KERNEL-1][KERNEL];	// older columns, [0] one column back
	pixel_t window [KERNEL][KERNEL];	// [r][c] counted back from the live pixel
	acc_t conv_sum [NUM_MAPS];	// bias plus products, before ReLU

	always_comb begin
		column[0] = pixel;
		for (int r = 1; r < KERNEL; r++)
			column[r] = taps[r-1];
	end

	// window slides one column per accepted pixel, row wrap garbage is never taken
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			win_q[0] <= column;
			for (int c = 1; c < KERNEL - 1; c++)
				win_q[c] <= win_q[c-1];
		end
	end

	always_comb begin
		for (int r = 0; r < KERNEL; r++) begin
			window[r][0] = column[r];
			for (int c = 1; c < KERNEL; c++)
				window[r][c] = win_q[c-1][r];
		end
	end

	always_comb begin
		for (int m = 0; m < NUM_MAPS; m++) begin
			conv_sum[m] = acc_t'(CONV_BIAS[m]);
			for (int r = 0; r < KERNEL; r++)
				for (int c = 0; c < KERNEL; c++)
					conv_sum[m] += acc_t'(window[r][c]) * acc_t'(KERNEL_TAPS[m][r][c]);
		end
	end

	always_ff @(posedge clk) begin
		if (conv_take) begin
			for (int m = 0; m < NUM_MAPS; m++)
				conv_out[m] <= (conv_sum[m] < 0) ? '0 : conv_sum[m];	// ReLU
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			conv_valid <= 1'b0;
		else
			conv_valid <= conv_take;
	end

	for (genvar m = 0; m < NUM_MAPS; m++) begin : g_relu_chk
		assert property (@(posedge clk) disable iff (reset)
				conv_valid |-> conv_out[m] >= 0)
			else $error("conv map %0d gave a negative result", m);
	end

endmodule

// ==== rtl/line_buffer.sv ====
module line_buffer #(
	parameter int IMAGE_COLS = 12
) (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input cnn_num_pkg::pixel_t pixel,
	output cnn_num_pkg::pixel_t taps [cnn_dims_pkg::KERNEL-1]	// [0] one row back, [3] oldest
);
	import cnn_dims_pkg::*;
	import cnn_num_pkg::*;

	localparam int ROWS = KERNEL - 1;	// live pixel supplies the fifth row
	localparam int PTR_W = $clog2(IMAGE_COLS);
	localparam logic [PTR_W-1:0] LAST_COL = PTR_W'(IMAGE_COLS - 1);

	pixel_t row_mem [ROWS][IMAGE_COLS];	// row r holds the image r+1 rows back
	logic [PTR_W-1:0] ptr;	// column slot of the live pixel

	always_ff @(posedge clk) begin
		if (reset)
			ptr <= '0;
		else if (pixel_valid)
			ptr <= (ptr == LAST_COL) ? '0 : ptr + 1'b1;
	end

	// each row pushes its old entry one memory down before taking the newer one
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			row_mem[0][ptr] <= pixel;
			for (int r = 1; r < ROWS; r++)
				row_mem[r][ptr] <= row_mem[r-1][ptr];
		end
	end

	always_comb begin
		for (int r = 0; r < ROWS; r++)
			taps[r] = row_mem[r][ptr];	// same column, earlier rows
	end

endmodule

// ==== rtl/frame_ctrl.sv ====
module frame_ctrl (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input logic [$clog2(cnn_dims_pkg::IMAGE_SIZE)-1:0] col,
	input logic [$clog2(cnn_dims_pkg::IMAGE_SIZE)-1:0] row,
	input logic frame_last,
	output logic conv_take,	// live pixel completes a full 5x5 window
	output logic pool_take,	// delayed, lines up with conv_valid
	output logic frame_done
);
	import cnn_dims_pkg::*;

	localparam int POS_W = $clog2(IMAGE_SIZE);
	localparam logic [POS_W-1:0] FIRST_FULL = POS_W'(KERNEL - 1);	// first full window position

	typedef enum logic [1:0] {IDLE, RUN, FINISH} state_t;

	state_t state, state_next;
	logic pool_hit;	// conv position closes a 2x2 block

	always_comb begin
		state_next = state;
		case (state)
			IDLE: if (pixel_valid) state_next = RUN;	// first pixel of a frame
			RUN: if (frame_last) state_next = FINISH;
			FINISH: state_next = pixel_valid ? RUN : IDLE;	// back to back frames skip IDLE
			default: state_next = IDLE;
		endcase
	end

	assign conv_take = (state == RUN) && pixel_valid && (row >= FIRST_FULL) && (col >= FIRST_FULL);

	// conv row and col are odd, measured from the first full window
	assign pool_hit = conv_take && (row[0] ^ FIRST_FULL[0]) && (col[0] ^ FIRST_FULL[0]);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			pool_take <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			state <= state_next;
			pool_take <= pool_hit;	// conv result is registered one cycle after its pixel
			// one cycle after FINISH, together with the last pooled value
			frame_done <= (state == FINISH);
		end
	end

	assert property (@(posedge clk) disable iff (reset) frame_done |=> !frame_done)
		else $error("frame_done held for more than one cycle");

endmodule

// ==== rtl/pixel_counter.sv ====
module pixel_counter #(
	parameter int IMAGE_COLS = 12
) (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	output logic [$clog2(IMAGE_COLS)-1:0] col,	// position of the pixel now on the bus
	output logic [$clog2(IMAGE_COLS)-1:0] row,
	output logic frame_last
);

	localparam int POS_W = $clog2(IMAGE_COLS);
	localparam logic [POS_W-1:0] LAST_POS = POS_W'(IMAGE_COLS - 1);	// frame is square

	logic row_end;	// current pixel closes its row

	assign row_end = (col == LAST_POS);
	assign frame_last = pixel_valid && row_end && (row == LAST_POS);

	// count only accepted pixels, gaps hold the position
	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (pixel_valid) begin
			if (row_end) begin
				col <= '0;
				row <= frame_last ? '0 : row + 1'b1;	// wrap into the next frame
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) col < IMAGE_COLS && row < IMAGE_COLS)
		else $error("pixel position left the frame");

endmodule

// ==== rtl/cnn_num_pkg.sv ====
package cnn_num_pkg;
	import cnn_dims_pkg::*;

	typedef logic signed [7:0] pixel_t;	// raw input sample
	typedef logic signed [7:0] weight_t;	// conv tap or conv bias
	typedef logic signed [23:0] acc_t;	// 25 full scale products plus bias fit easily
	typedef logic signed [3:0] dense_w_t;	// small dense weights
	typedef logic signed [31:0] score_t;	// class score accumulator

	// taps [map][r][c], r and c counted back from the newest pixel of the window
	localparam weight_t KERNEL_TAPS [NUM_MAPS][KERNEL][KERNEL] = '{
		'{	// map 0, vertical edge response
			'{ 1,  2,  0, -2, -1},
			'{ 2,  3,  0, -3, -2},
			'{ 3,  4,  1, -4, -3},
			'{ 2,  3,  0, -3, -2},
			'{ 1,  2,  0, -2, -1}
		},
		'{	// map 1, center surround
			'{-1, -1, -2, -1, -1},
			'{-1,  2,  3,  2, -1},
			'{-2,  3,  6,  3, -2},
			'{-1,  2,  3,  2, -1},
			'{-1, -1, -2, -1, -1}
		}
	};

	localparam weight_t CONV_BIAS [NUM_MAPS] = '{-8, 4};

	// [class][map * 16 + pooled row * 4 + pooled col]
	localparam dense_w_t DENSE_WEIGHTS [NUM_CLASSES][DENSE_INPUTS] = '{
		'{ 1,  2,  0, -1,  3,  1, -2,  0,  2,  1,  0, -3,  1,  0,  2, -1,
		  -1,  0,  2,  1, -2,  3,  0,  1,  1, -1,  2,  0,  0,  2, -1,  1},
		'{-2,  1,  3,  0,  1, -1,  2,  2,  0,  3, -2,  1,  2,  1, -1,  0,
		   2, -1,  0,  3,  1,  0, -2,  1,  3,  0,  1, -1, -2,  1,  0,  2},
		'{ 0, -1,  1,  2, -2,  0,  3,  1, -1,  2,  1,  0,  3, -2,  0,  1,
		   1,  2, -1,  0,  0,  1,  2, -3,  0,  1,  3,  2,  1, -1,  0, -2},
		'{ 3,  0, -1,  1,  0,  2,  1, -2,  1,  0, -1,  2,  0,  1,  3,  0,
		   0,  1,  1, -2,  2,  0, -1,  3, -2,  2,  0,  1,  2,  0,  1, -1}
	};

endpackage

// ==== rtl/cnn_dims_pkg.sv ====
package cnn_dims_pkg;

	// input frame, square
	localparam int IMAGE_SIZE = 12;

	localparam int KERNEL = 5;	// conv window side, 5x5 as in C1
	localparam int CONV_SIZE = IMAGE_SIZE - KERNEL + 1;	// valid conv positions per side, 8
	localparam int POOL_SIZE = CONV_SIZE / 2;	// 2x2 max pooling with stride 2

	localparam int NUM_MAPS = 2;	// conv feature maps
	localparam int NUM_CLASSES = 4;	// dense output neurons

	// flattened pooled values of one frame, map major
	localparam int DENSE_INPUTS = NUM_MAPS * POOL_SIZE * POOL_SIZE;

	localparam int CLASS_W = $clog2(NUM_CLASSES);	// width of the class index

endpackage
